// ==== Makefile ====
SRCS := $(wildcard logic/*.sv tb/*.sv)

.PHONY: all run clean

all: run

obj_dir/VtbRiscCore: $(SRCS) filelist.f
	verilator --binary --assert --timing --top-module tbRiscCore -f filelist.f -Mdir obj_dir

run: obj_dir/VtbRiscCore
	-./obj_dir/VtbRiscCore | tee sim.log
	@if grep -q "Testbench failed" sim.log; then exit 1; fi
	@grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== filelist.f ====
logic/riscPkg.sv
logic/fetchUnit.sv
logic/registerFile.sv
logic/operandStage.sv
logic/executeStage.sv
logic/riscCore.sv
tb/refChecker.sv
tb/tbRiscCore.sv

// ==== logic/executeStage.sv ====
module executeStage
    import riscPkg::*;
(
    input  logic   Clock_pin,
    input  logic   rstN,
    input  issueT  issue,
    output commitT commit
);

    logic                   isSub;
    logic [DataWidth-1:0]   addendB;       // B, inverted for subtract
    logic [DataWidth:0]     sum;           // top bit is the carry out
    logic [ShiftWidth-1:0]  rotAmt;        // amount modulo the word width
    logic [2*DataWidth-1:0] rotLeft;
    logic [2*DataWidth-1:0] rotRight;
    logic [DataWidth-1:0]   result;
    flagsT                  flags;
    logic                   writesFlags;

    logic                   validQ;
    logic [RegIdxWidth-1:0] destQ;
    logic [DataWidth-1:0]   resultQ;
    flagsT                  flagsQ;
    logic                   writesFlagsQ;

    //--------------------------------------------------------------------
    // adder, shared by add and subtract
    //--------------------------------------------------------------------
    assign isSub   = (issue.opcode == OpSub) || (issue.opcode == OpSubc);
    assign addendB = isSub ? ~issue.opB : issue.opB;
    assign sum     = {1'b0, issue.opA} + {1'b0, addendB}
                   + {{DataWidth{1'b0}}, isSub};          // +1 completes the negate

    // rotates through a doubled word
    assign rotAmt   = (issue.shiftAmt >= ShiftWidth'(DataWidth))
                    ? issue.shiftAmt - ShiftWidth'(DataWidth)
                    : issue.shiftAmt;
    assign rotLeft  = {issue.opA, issue.opA} << rotAmt;
    assign rotRight = {issue.opA, issue.opA} >> rotAmt;

    //--------------------------------------------------------------------
    // result and flags
    //--------------------------------------------------------------------
    always_comb begin
        result         = issue.opA;
        writesFlags    = 1'b1;
        flags.carry    = 1'b0;
        flags.overflow = 1'b0;
        case (issue.opcode)
            OpCpy: begin
                result      = issue.opB;
                writesFlags = 1'b0;
            end
            OpAdd, OpSub, OpAddc, OpSubc: begin
                result         = sum[DataWidth-1:0];
                flags.carry    = sum[DataWidth];
                flags.overflow = (issue.opA[DataWidth-1] == addendB[DataWidth-1])
                              && (sum[DataWidth-1] != issue.opA[DataWidth-1]);
            end
            OpNot: begin
                result = ~issue.opA;
            end
            OpAnd: begin
                result = issue.opA & issue.opB;
            end
            OpOr: begin
                result = issue.opA | issue.opB;
            end
            OpXor: begin
                result = issue.opA ^ issue.opB;
            end
            OpShll, OpShla: begin
                result      = issue.opA << issue.shiftAmt;   // 14 and up clear the word
                writesFlags = 1'b0;
            end
            OpShrl: begin
                result      = issue.opA >> issue.shiftAmt;
                writesFlags = 1'b0;
            end
            OpShra: begin
                result      = $signed(issue.opA) >>> issue.shiftAmt;   // saturates to sign
                writesFlags = 1'b0;
            end
            OpRotl: begin
                result      = rotLeft[2*DataWidth-1:DataWidth];
                writesFlags = 1'b0;
            end
            OpRotr: begin
                result      = rotRight[DataWidth-1:0];
                writesFlags = 1'b0;
            end
            default: begin
                result      = '0;     // never marked valid upstream
                writesFlags = 1'b0;
            end
        endcase
        flags.negative = result[DataWidth-1];
        flags.zero     = (result == '0);
    end

    //--------------------------------------------------------------------
    // commit register
    //--------------------------------------------------------------------
    always_ff @(posedge Clock_pin or negedge rstN) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else begin
            validQ <= issue.valid;
        end
    end

    always_ff @(posedge Clock_pin) begin
        destQ        <= issue.dest;
        resultQ      <= result;
        flagsQ       <= flags;
        writesFlagsQ <= writesFlags;
    end

    assign commit = '{
        valid:       validQ,
        dest:        destQ,
        result:      resultQ,
        flags:       flagsQ,
        writesFlags: writesFlagsQ
    };

    // operand decode must have dropped every NOP
    noNopCommit: assert property (
        @(posedge Clock_pin) disable iff (!rstN)
        commit.valid |-> $past(issue.opcode) != OpNop
    ) else $error("valid commit from a NOP");

endmodule

// ==== logic/fetchUnit.sv ====
module fetchUnit
    import riscPkg::*;
(
    input  logic                 Clock_pin,
    input  logic                 rstN,
    input  instrT                instr,
    output logic [DataWidth-1:0] pc,
    output instrT                fetched,
    output logic                 fetchedValid
);

    logic wordPending;   // memory is answering the previous pc

    //--------------------------------------------------------------------
    // program counter, steps every cycle, no branches
    //--------------------------------------------------------------------
    always_ff @(posedge Clock_pin or negedge rstN) begin
        if (!rstN) begin
            pc           <= ResetPc;
            wordPending  <= 1'b0;
            fetchedValid <= 1'b0;
        end else begin
            pc           <= pc + DataWidth'(1);
            wordPending  <= 1'b1;           // first address went out
            fetchedValid <= wordPending;    // first word lands one cycle later
        end
    end

    // instruction register
    always_ff @(posedge Clock_pin) begin
        fetched <= instr;
    end

    // the fetch stream never stalls or jumps
    pcStep: assert property (
        @(posedge Clock_pin) disable iff (!rstN)
        $past(rstN) |-> pc == $past(pc) + DataWidth'(1)
    ) else $error("pc did not step by one");

endmodule

// ==== logic/operandStage.sv ====
module operandStage
    import riscPkg::*;
(
    input  logic                   Clock_pin,
    input  logic                   rstN,
    input  instrT                  fetched,
    input  logic                   fetchedValid,
    output logic [RegIdxWidth-1:0] readIdxA,
    output logic [RegIdxWidth-1:0] readIdxB,
    input  logic [DataWidth-1:0]   readA,
    input  logic [DataWidth-1:0]   readB,
    input  commitT                 inFlight,
    output issueT                  issue
);

    logic                   isKnown;     // opcode produces a commit
    logic                   useRegA;     // operand A read from a register
    logic                   useRegB;     // otherwise the constant
    logic [DataWidth-1:0]   constB;
    logic                   validQ;
    logic                   fwdEnAQ;
    logic                   fwdEnBQ;
    opcodeE                 opcodeQ;
    logic [RegIdxWidth-1:0] destQ;
    logic [RegIdxWidth-1:0] srcBQ;
    logic [DataWidth-1:0]   opAQ;
    logic [DataWidth-1:0]   opBQ;
    logic [ShiftWidth-1:0]  shiftQ;

    assign readIdxA = fetched.regA;
    assign readIdxB = fetched.regB;
    assign constB   = DataWidth'(fetched.regB);   // zero-extended

    //--------------------------------------------------------------------
    // decode
    //--------------------------------------------------------------------
    always_comb begin
        isKnown = 1'b1;
        useRegA = 1'b1;
        useRegB = 1'b0;
        case (fetched.opcode)
            OpCpy: begin
                useRegA = 1'b0;
                useRegB = 1'b1;
            end
            OpAdd, OpSub, OpAnd, OpOr, OpXor: begin
                useRegB = 1'b1;
            end
            OpAddc, OpSubc, OpNot, OpShll, OpShrl, OpShla, OpShra, OpRotl, OpRotr: begin
                useRegB = 1'b0;                   // constant or amount field
            end
            default: begin
                isKnown = 1'b0;                   // NOP and unused codes
                useRegA = 1'b0;
            end
        endcase
    end

    always_ff @(posedge Clock_pin or negedge rstN) begin
        if (!rstN) begin
            validQ  <= 1'b0;
            fwdEnAQ <= 1'b0;
            fwdEnBQ <= 1'b0;
        end else begin
            validQ  <= fetchedValid && isKnown;
            fwdEnAQ <= fetchedValid && useRegA;
            fwdEnBQ <= fetchedValid && useRegB;
        end
    end

    always_ff @(posedge Clock_pin) begin
        opcodeQ <= fetched.opcode;
        destQ   <= fetched.regA;      // also the A source index
        srcBQ   <= fetched.regB;
        opAQ    <= readA;
        opBQ    <= useRegB ? readB : constB;
        shiftQ  <= fetched.regB;
    end

    //--------------------------------------------------------------------
    // forwarding from the commit that is in flight
    //--------------------------------------------------------------------
    always_comb begin
        issue.valid    = validQ;
        issue.opcode   = opcodeQ;
        issue.dest     = destQ;
        issue.shiftAmt = shiftQ;
        issue.opA      = opAQ;
        issue.opB      = opBQ;
        if (fwdEnAQ && inFlight.valid && inFlight.dest == destQ) begin
            issue.opA = inFlight.result;   // previous instruction's result
        end
        if (fwdEnBQ && inFlight.valid && inFlight.dest == srcBQ) begin
            issue.opB = inFlight.result;
        end
    end

endmodule

// ==== logic/registerFile.sv ====
module registerFile
    import riscPkg::*;
(
    input  logic                   Clock_pin,
    input  logic                   rstN,
    input  logic [RegIdxWidth-1:0] readIdxA,
    input  logic [RegIdxWidth-1:0] readIdxB,
    output logic [DataWidth-1:0]   readA,
    output logic [DataWidth-1:0]   readB,
    input  commitT                 commit,
    output flagsT                  status
);

    logic [DataWidth-1:0] regs [RegCount];

    //--------------------------------------------------------------------
    // write port, driven by the commit record
    //--------------------------------------------------------------------
    always_ff @(posedge Clock_pin or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (commit.valid) begin
            regs[commit.dest] <= commit.result;
        end
    end

    // status register, only flag-producing ops load it
    always_ff @(posedge Clock_pin or negedge rstN) begin
        if (!rstN) begin
            status <= '0;
        end else if (commit.valid && commit.writesFlags) begin
            status <= commit.flags;
        end
    end

    //--------------------------------------------------------------------
    // read ports
    //--------------------------------------------------------------------
    // same-cycle write shows up on the read
    function automatic logic [DataWidth-1:0] readPort(
        input logic [RegIdxWidth-1:0] idx,
        input commitT                 wr,
        input logic [DataWidth-1:0]   stored
    );
        if (wr.valid && wr.dest == idx) begin
            return wr.result;
        end
        return stored;
    endfunction

    assign readA = readPort(readIdxA, commit, regs[readIdxA]);
    assign readB = readPort(readIdxB, commit, regs[readIdxB]);

endmodule

// ==== logic/riscCore.sv ====
module riscCore
    import riscPkg::*;
(
    input  logic                 Clock_pin,
    input  logic                 rstN,
    output logic [DataWidth-1:0] pc,
    input  instrT                instr,
    output commitT               commit,
    output flagsT                status
);

    instrT                  fetched;
    logic                   fetchedValid;
    logic [RegIdxWidth-1:0] readIdxA;
    logic [RegIdxWidth-1:0] readIdxB;
    logic [DataWidth-1:0]   readA;
    logic [DataWidth-1:0]   readB;
    issueT                  issue;

    //--------------------------------------------------------------------
    // fetch -> operand read -> execute -> commit
    //--------------------------------------------------------------------
    fetchUnit uFetch (
        .Clock_pin    (Clock_pin),
        .rstN         (rstN),
        .instr        (instr),
        .pc           (pc),
        .fetched      (fetched),
        .fetchedValid (fetchedValid)
    );

    operandStage uOperand (
        .Clock_pin    (Clock_pin),
        .rstN         (rstN),
        .fetched      (fetched),
        .fetchedValid (fetchedValid),
        .readIdxA     (readIdxA),
        .readIdxB     (readIdxB),
        .readA        (readA),
        .readB        (readB),
        .inFlight     (commit),        // forwarding path
        .issue        (issue)
    );

    executeStage uExecute (
        .Clock_pin (Clock_pin),
        .rstN      (rstN),
        .issue     (issue),
        .commit    (commit)
    );

    registerFile uRegs (
        .Clock_pin (Clock_pin),
        .rstN      (rstN),
        .readIdxA  (readIdxA),
        .readIdxB  (readIdxB),
        .readA     (readA),
        .readB     (readB),
        .commit    (commit),
        .status    (status)
    );

endmodule

// ==== logic/riscPkg.sv ====
package riscPkg;

    //--------------------------------------------------------------------
    // machine dimensions
    //--------------------------------------------------------------------
    localparam int DataWidth   = 14;                 // machine word
    localparam int RegCount    = 16;                 // general registers
    localparam int RegIdxWidth = 4;
    localparam int OpcodeWidth = 6;
    localparam int ShiftWidth  = 4;                  // shift and rotate amount

    localparam logic [DataWidth-1:0] ResetPc = '0;   // first fetch address

    //--------------------------------------------------------------------
    // instruction set, reference encodings
    //--------------------------------------------------------------------
    typedef enum logic [OpcodeWidth-1:0] {
        OpNop  = 6'h00,
        OpCpy  = 6'h03,
        OpAdd  = 6'h20,
        OpSub  = 6'h21,
        OpAddc = 6'h22,   // 4-bit constant
        OpSubc = 6'h23,   // 4-bit constant
        OpNot  = 6'h28,
        OpAnd  = 6'h29,
        OpOr   = 6'h2A,
        OpXor  = 6'h2B,
        OpShll = 6'h2C,
        OpShrl = 6'h2D,
        OpShla = 6'h2E,
        OpShra = 6'h2F,
        OpRotl = 6'h30,
        OpRotr = 6'h31
    } opcodeE;

    typedef struct packed {
        opcodeE                 opcode;   // bits 13:8
        logic [RegIdxWidth-1:0] regA;     // destination and first source
        logic [RegIdxWidth-1:0] regB;     // second source, constant or amount
    } instrT;

    typedef struct packed {
        logic carry;
        logic negative;
        logic overflow;
        logic zero;
    } flagsT;

    // operand stage to execute stage
    typedef struct packed {
        logic                   valid;
        opcodeE                 opcode;
        logic [RegIdxWidth-1:0] dest;
        logic [DataWidth-1:0]   opA;
        logic [DataWidth-1:0]   opB;
        logic [ShiftWidth-1:0]  shiftAmt;
    } issueT;

    // result leaving the execute stage
    typedef struct packed {
        logic                   valid;
        logic [RegIdxWidth-1:0] dest;
        logic [DataWidth-1:0]   result;
        flagsT                  flags;
        logic                   writesFlags;   // status loads at commit
    } commitT;

endpackage

// ==== tb/refChecker.sv ====
module refChecker
    import riscPkg::*;
(
    input  logic                 Clock_pin,
    input  logic                 rstN,
    input  logic [DataWidth-1:0] pc,
    input  instrT                instr,
    input  commitT               commit,
    input  flagsT                status,
    output logic                 failed
);
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic                   valid;
        logic [RegIdxWidth-1:0] dest;
        logic [DataWidth-1:0]   result;
        flagsT                  stat;     // model status once this slot is done
    } expectT;

    logic [DataWidth-1:0] model [RegCount];
    flagsT                modelStat;
    logic                 pending;          // memory is answering a real pc
    logic [DataWidth-1:0] pcExp;
    expectT               e1, e2, e3, e4;   // one per pipeline edge

    //--------------------------------------------------------------------
    // reference model, one instruction per captured word
    //--------------------------------------------------------------------
    function automatic expectT runModel(input instrT w);
        expectT               e;
        logic [DataWidth-1:0] a;
        logic [DataWidth-1:0] b;
        logic [DataWidth:0]   wide;
        int                   n;
        int                   m;
        logic                 isFlagOp;
        a = model[w.regA];
        b = model[w.regB];
        n = int'(w.regB);
        m = n % DataWidth;
        e = '{valid: 1'b1, dest: w.regA, result: '0, stat: modelStat};
        isFlagOp = 1'b1;
        case (w.opcode)
            OpCpy:  begin e.result = b; isFlagOp = 1'b0; end
            OpAdd, OpAddc, OpSub, OpSubc: begin
                if (w.opcode == OpAddc || w.opcode == OpSubc) begin
                    b = DataWidth'(w.regB);                  // constant
                end
                if (w.opcode == OpSub || w.opcode == OpSubc) begin
                    wide = {1'b0, a} + {1'b0, ~b} + 1;
                    e.stat.overflow = (a[13] != b[13]) && (wide[13] != a[13]);
                end else begin
                    wide = {1'b0, a} + {1'b0, b};
                    e.stat.overflow = (a[13] == b[13]) && (wide[13] != a[13]);
                end
                e.result = wide[DataWidth-1:0];
                e.stat.carry = wide[DataWidth];
            end
            OpNot:  e.result = ~a;
            OpAnd:  e.result = a & b;
            OpOr:   e.result = a | b;
            OpXor:  e.result = a ^ b;
            OpShll, OpShla: begin
                e.result = (n >= DataWidth) ? '0 : a << n;
                isFlagOp = 1'b0;
            end
            OpShrl: begin
                e.result = (n >= DataWidth) ? '0 : a >> n;
                isFlagOp = 1'b0;
            end
            OpShra: begin
                if (n >= DataWidth) e.result = {DataWidth{a[13]}};
                else e.result = (a >> n) | (a[13] ? ~(14'h3FFF >> n) : 14'h0);
                isFlagOp = 1'b0;
            end
            OpRotl: begin e.result = (a << m) | (a >> (DataWidth - m)); isFlagOp = 1'b0; end
            OpRotr: begin e.result = (a >> m) | (a << (DataWidth - m)); isFlagOp = 1'b0; end
            default: begin e.valid = 1'b0; isFlagOp = 1'b0; end   // NOP, unused code
        endcase
        if (isFlagOp) begin
            if (!(w.opcode inside {OpAdd, OpAddc, OpSub, OpSubc})) begin
                e.stat.carry    = 1'b0;
                e.stat.overflow = 1'b0;
            end
            e.stat.negative = e.result[DataWidth-1];
            e.stat.zero     = (e.result == '0);
            modelStat = e.stat;
        end
        if (e.valid) model[w.regA] = e.result;
        return e;
    endfunction

    always @(posedge Clock_pin or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < RegCount; i++) model[i] = '0;
            modelStat = '0;
            pending <= 1'b0;
            pcExp   <= '0;
            e1 <= '0;
            e2 <= '0;
            e3 <= '0;
            e4 <= '0;
        end else begin
            pending <= 1'b1;
            pcExp   <= pcExp + 1'b1;
            e1 <= pending ? runModel(instr) : '{valid: 1'b0, dest: '0, result: '0, stat: modelStat};
            e2 <= e1;
            e3 <= e2;
            e4 <= e3;
        end
    end

    //--------------------------------------------------------------------
    // checks
    //--------------------------------------------------------------------
    resetQuiet: assert property (@(posedge Clock_pin) !rstN |-> !commit.valid && status == '0)
        else begin $display("** Error: commit.valid/status active in reset: %h %h",
            $sampled(commit.valid), $sampled(status)); failed = 1'b1; end
    pcCount: assert property (@(posedge Clock_pin) disable iff (!rstN) pc == pcExp)
        else begin $display("** Error: pc = %h, expected %h", $sampled(pc),
            $sampled(pcExp)); failed = 1'b1; end
    validMatch: assert property (@(posedge Clock_pin) disable iff (!rstN) commit.valid == e3.valid)
        else begin $display("** Error: commit.valid = %h, expected %h",
            $sampled(commit.valid), $sampled(e3.valid)); failed = 1'b1; end
    destMatch: assert property (@(posedge Clock_pin) disable iff (!rstN)
        commit.valid |-> commit.dest == e3.dest)
        else begin $display("** Error: commit.dest = %h, expected %h",
            $sampled(commit.dest), $sampled(e3.dest)); failed = 1'b1; end
    resultMatch: assert property (@(posedge Clock_pin) disable iff (!rstN)
        commit.valid |-> commit.result == e3.result)
        else begin $display("** Error: commit.result = %h, expected %h",
            $sampled(commit.result), $sampled(e3.result)); failed = 1'b1; end
    statusMatch: assert property (@(posedge Clock_pin) disable iff (!rstN) status == e4.stat)
        else begin $display("** Error: status = %h, expected %h",
            $sampled(status), $sampled(e4.stat)); failed = 1'b1; end

endmodule

// ==== tb/tbRiscCore.sv ====
module tbRiscCore
    import riscPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ProgWords      = 512;
    localparam int EndPc          = ProgWords + 4;    // last word has committed
    localparam int WatchdogCycles = ProgWords + 88;

    logic                 Clock_pin;
    logic                 rstN;
    logic [DataWidth-1:0] pc;
    instrT                instr = '0;
    commitT               commit;
    flagsT                status;
    logic                 failed;

    logic [DataWidth-1:0] prog [ProgWords];

    riscCore DUT (
        .Clock_pin (Clock_pin),
        .rstN      (rstN),
        .pc        (pc),
        .instr     (instr),
        .commit    (commit),
        .status    (status)
    );

    refChecker uChecker (
        .Clock_pin (Clock_pin),
        .rstN      (rstN),
        .pc        (pc),
        .instr     (instr),
        .commit    (commit),
        .status    (status),
        .failed    (failed)
    );

    // every implemented opcode plus some NOPs and one unused code
    function automatic logic [OpcodeWidth-1:0] pickOpcode(input int unsigned r);
        case (r % 20)
            0:  return OpCpy;
            1:  return OpAdd;
            2:  return OpSub;
            3:  return OpAddc;
            4:  return OpSubc;
            5:  return OpNot;
            6:  return OpAnd;
            7:  return OpOr;
            8:  return OpXor;
            9:  return OpShll;
            10: return OpShrl;
            11: return OpShla;
            12: return OpShra;
            13: return OpRotl;
            14: return OpRotr;
            15, 16, 17: return OpNop;
            default: return 6'h3F;
        endcase
    endfunction

    //--------------------------------------------------------------------
    // clock, program memory
    //--------------------------------------------------------------------
    initial begin
        Clock_pin = 1'b0;
        forever #5 Clock_pin = ~Clock_pin;
    end

    always @(posedge Clock_pin) begin
        instr <= instrT'(prog[pc[8:0]]);   // answers one cycle later
    end

    always @(posedge failed) begin
        $display("Testbench failed");
        $fatal(1, "result differs from the reference model");
    end

    initial begin
        repeat (WatchdogCycles) @(posedge Clock_pin);
        $display("run did not finish within %0d cycles", WatchdogCycles);
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

    //--------------------------------------------------------------------
    // main sequence
    //--------------------------------------------------------------------
    initial begin
        void'($urandom(32'he140_4127));
        rstN = 1'b0;
        for (int i = 0; i < ProgWords; i++) begin
            prog[i] = {pickOpcode($urandom), 4'($urandom), 4'($urandom)};
        end
        // directed start that overflows the adder both ways
        prog[0] = {OpNot,  4'd1, 4'd0};    // r1 = 3FFF
        prog[1] = {OpShrl, 4'd1, 4'd1};    // r1 = 1FFF
        prog[2] = {OpAddc, 4'd1, 4'd1};    // r1 = 2000 with signed overflow
        prog[3] = {OpSubc, 4'd1, 4'd1};    // r1 = 1FFF with signed overflow
        prog[4] = {OpAdd,  4'd1, 4'd1};    // r1 = 3FFE with signed overflow
        repeat (5) @(posedge Clock_pin);
        rstN <= 1'b1;
        while (pc < DataWidth'(EndPc)) @(posedge Clock_pin);
        repeat (2) @(posedge Clock_pin);
        if (failed === 1'b1) begin
            $display("Testbench failed");
            $fatal(1, "checks reported a mismatch");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule
